// File: Bender.yml
package:
  name: i2c_master

sources:
  - hdl/i2c_pkg.sv
  - hdl/i2c_bit_timer.sv
  - hdl/i2c_shift_reg.sv
  - hdl/i2c_master_fsm.sv
  - hdl/i2c_master_top.sv
  - target: simulation
    files:
      - sim/i2c_slave_model.sv
      - sim/tb_i2c_master.sv

// File: hdl/i2c_bit_timer.sv
module i2c_bit_timer
  import i2c_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       run,    // High for the whole transaction
  output logic       tick,   // One cycle every QUARTER_CLKS cycles
  output logic [1:0] phase   // Quarter of the current bit slot
);

  logic [QUARTER_W-1:0] div_q;    // Quarter divider
  logic [1:0]           phase_q;  // Quarter counter, wraps every slot

  // Not gated by run, the FSM only drops run on a slot boundary
  assign tick  = (div_q == QUARTER_W'(QUARTER_CLKS - 1));
  assign phase = phase_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_q   <= '0;
      phase_q <= '0;
    end else if (!run) begin
      div_q   <= '0;  // Idle bus, hold at start of slot
      phase_q <= '0;
    end else if (tick) begin
      div_q   <= '0;
      phase_q <= phase_q + 2'd1;  // Next quarter
    end else begin
      div_q   <= div_q + QUARTER_W'(1);
    end
  end

  // The FSM must stop the timer only when the divider has wrapped
  a_no_tick_idle : assert property (
    @(posedge clk) disable iff (reset)
    !run |-> !tick
  ) else $error("Bit timer ticked while run is low");

endmodule

// File: hdl/i2c_master_fsm.sv
module i2c_master_fsm
  import i2c_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,       // Command strobe
  input  i2c_cmd_t   cmd,
  input  logic       tick,        // Quarter tick from the bit timer
  input  logic [1:0] phase,
  output logic       run,         // Enables the bit timer
  output logic       load,        // Shift register load strobe
  output logic [7:0] load_data,
  output logic       bit_shift,   // Shift register shift strobe
  input  logic       msb,
  input  logic [7:0] shift_data,
  input  logic       sda_in,      // Sampled SDA level
  output logic       scl_low,     // Open-drain pull-down on SCL
  output logic       sda_low,     // Open-drain pull-down on SDA
  output logic       busy,
  output logic       done,        // Result strobe
  output i2c_rsp_t   rsp
);

  i2c_state_e state_q;
  i2c_cmd_t   cmd_q;      // Latched command
  i2c_rsp_t   res_q;      // Result under construction
  i2c_rsp_t   rsp_q;      // Last finished result
  logic [2:0] bit_cnt_q;  // Bits left in the byte
  logic       run_q;
  logic       busy_q;
  logic       scl_low_q;
  logic       sda_low_q;
  logic       accept;
  logic       tick_drive;
  logic       tick_rise;
  logic       tick_sample;
  logic       tick_end;

  assign accept      = start && !busy_q;  // Starts while busy are dropped
  assign tick_drive  = tick && (phase == PH_DRIVE);
  assign tick_rise   = tick && (phase == PH_RISE);
  assign tick_sample = tick && (phase == PH_SAMPLE);
  assign tick_end    = tick && (phase == PH_END);

  // Address byte at end of START, write data after a good address ACK
  assign load = tick_end && ((state_q == ST_START) ||
                ((state_q == ST_ADDR_ACK) && !res_q.addr_nack && !cmd_q.rw));
  assign load_data = (state_q == ST_START) ? {cmd_q.addr, cmd_q.rw} : cmd_q.wdata;

  // TX shifts after driving a bit, RX shifts on the sample point
  assign bit_shift = (tick_drive && ((state_q == ST_ADDR) || (state_q == ST_WRITE))) ||
                     (tick_sample && (state_q == ST_READ));

  assign done    = tick_end && (state_q == ST_STOP);  // Same cycle SDA is released
  assign rsp     = done ? res_q : rsp_q;
  assign run     = run_q;
  assign busy    = busy_q;
  assign scl_low = scl_low_q;
  assign sda_low = sda_low_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q   <= ST_IDLE;
      res_q     <= '0;
      rsp_q     <= '0;
      bit_cnt_q <= '0;
      run_q     <= 1'b0;
      busy_q    <= 1'b0;
      scl_low_q <= 1'b0;
      sda_low_q <= 1'b0;
    end else begin
      if (done) rsp_q <= res_q;
      if (tick_rise) scl_low_q <= 1'b0;                            // SCL high for phases 2, 3
      if (tick_end && (state_q != ST_STOP)) scl_low_q <= 1'b1;     // SCL low for next slot
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_START;
            res_q   <= '0;
            run_q   <= 1'b1;
            busy_q  <= 1'b1;
          end
        end
        ST_START: begin
          if (tick_sample) sda_low_q <= 1'b1;  // START, SCL still high
          if (tick_end) begin
            state_q   <= ST_ADDR;
            bit_cnt_q <= 3'd7;
          end
        end
        ST_ADDR: begin
          if (tick_drive) sda_low_q <= !msb;
          if (tick_end) begin
            bit_cnt_q <= bit_cnt_q - 3'd1;  // Wraps to 7 for the data byte
            if (bit_cnt_q == 3'd0) state_q <= ST_ADDR_ACK;
          end
        end
        ST_ADDR_ACK: begin
          if (tick_drive) sda_low_q <= 1'b0;         // Hand SDA to the slave
          if (tick_sample) res_q.addr_nack <= sda_in;
          if (tick_end) begin
            if (res_q.addr_nack) state_q <= ST_STOP;  // Skip the data phase
            else if (cmd_q.rw) state_q <= ST_READ;
            else state_q <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (tick_drive) sda_low_q <= !msb;
          if (tick_end) begin
            bit_cnt_q <= bit_cnt_q - 3'd1;
            if (bit_cnt_q == 3'd0) state_q <= ST_DATA_ACK;
          end
        end
        ST_READ: begin
          if (tick_drive) sda_low_q <= 1'b0;  // Slave drives the data
          if (tick_end) begin
            bit_cnt_q <= bit_cnt_q - 3'd1;
            if (bit_cnt_q == 3'd0) state_q <= ST_DATA_ACK;
          end
        end
        ST_DATA_ACK: begin
          if (tick_drive) sda_low_q <= 1'b0;  // Released, so a read answers NACK
          if (tick_sample) begin
            if (cmd_q.rw) res_q.rdata <= shift_data;  // Read complete
            else res_q.data_nack <= sda_in;
          end
          if (tick_end) state_q <= ST_STOP;
        end
        ST_STOP: begin
          if (tick_drive) sda_low_q <= 1'b1;  // SDA low before SCL rises
          if (tick_end) begin
            sda_low_q <= 1'b0;  // STOP, SDA rises with SCL high
            state_q   <= ST_IDLE;
            run_q     <= 1'b0;
            busy_q    <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  a_done_busy : assert property (
    @(posedge clk) disable iff (reset)
    done |-> busy_q
  ) else $error("done pulsed without busy");

  a_idle_scl : assert property (
    @(posedge clk) disable iff (reset)
    (state_q == ST_IDLE) |-> !scl_low_q
  ) else $error("SCL held low on an idle bus");

endmodule

// File: hdl/i2c_master_top.sv
module i2c_master_top
  import i2c_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     start,    // Command strobe, ignored while busy
  input  i2c_cmd_t cmd,
  output logic     busy,
  output logic     done,     // Result strobe
  output i2c_rsp_t rsp,
  input  logic     sda_in,   // Wired SDA level
  output logic     scl_low,  // Open-drain SCL control
  output logic     sda_low   // Open-drain SDA control
);

  logic       tick;
  logic [1:0] phase;
  logic       run;
  logic       load;
  logic [7:0] load_data;
  logic       bit_shift;
  logic       msb;
  logic [7:0] shift_data;

  i2c_bit_timer i_timer (
    .clk   (clk),
    .reset (reset),
    .run   (run),
    .tick  (tick),
    .phase (phase)
  );

  i2c_shift_reg i_shift (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .load_data (load_data),
    .bit_shift (bit_shift),
    .serial_in (sda_in),  // RX bits enter straight from the bus
    .msb       (msb),
    .data      (shift_data)
  );

  i2c_master_fsm i_fsm (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .cmd        (cmd),
    .tick       (tick),
    .phase      (phase),
    .run        (run),
    .load       (load),
    .load_data  (load_data),
    .bit_shift  (bit_shift),
    .msb        (msb),
    .shift_data (shift_data),
    .sda_in     (sda_in),
    .scl_low    (scl_low),
    .sda_low    (sda_low),
    .busy       (busy),
    .done       (done),
    .rsp        (rsp)
  );

endmodule

// File: hdl/i2c_pkg.sv
package i2c_pkg;

  // Bit timing
  localparam int QUARTER_CLKS  = 5;                      // clk cycles per quarter SCL period
  localparam int QUARTER_W     = $clog2(QUARTER_CLKS);   // Divider counter width
  localparam int BIT_SLOTS_MAX = 20;                     // START, 2 x (8 bits + ACK), STOP

  // Quarter phases inside one bit slot
  localparam logic [1:0] PH_DRIVE  = 2'd0;  // SCL low, SDA may change
  localparam logic [1:0] PH_RISE   = 2'd1;  // SCL low, released on its tick
  localparam logic [1:0] PH_SAMPLE = 2'd2;  // SCL high, bus sampled on its tick
  localparam logic [1:0] PH_END    = 2'd3;  // SCL high, slot ends on its tick

  // Sequencer states
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,  // Bus released, waiting for start
    ST_START    = 3'd1,  // SDA falls with SCL high
    ST_ADDR     = 3'd2,  // 7 address bits plus R/W
    ST_ADDR_ACK = 3'd3,  // Slave acknowledges the address
    ST_WRITE    = 3'd4,  // Master sends the data byte
    ST_READ     = 3'd5,  // Master receives the data byte
    ST_DATA_ACK = 3'd6,  // Slave ACK on write, master NACK on read
    ST_STOP     = 3'd7   // SDA rises with SCL high
  } i2c_state_e;

  // Command from the user side
  typedef struct packed {
    logic [6:0] addr;   // Slave address
    logic       rw;     // 1 = read
    logic [7:0] wdata;  // Byte to send on a write
  } i2c_cmd_t;

  // Result returned with done
  typedef struct packed {
    logic [7:0] rdata;      // Received byte, 0 unless a read completed
    logic       addr_nack;  // Address not acknowledged
    logic       data_nack;  // Write data not acknowledged
  } i2c_rsp_t;

endpackage

// File: hdl/i2c_shift_reg.sv
module i2c_shift_reg (
  input  logic       clk,
  input  logic       reset,
  input  logic       load,       // Parallel load strobe
  input  logic [7:0] load_data,  // Address byte or write data
  input  logic       bit_shift,  // Shift left by one
  input  logic       serial_in,  // Sampled SDA, enters at LSB
  output logic       msb,        // Next bit to send
  output logic [7:0] data        // Received byte after eight shifts
);

  logic [7:0] data_q;

  assign msb  = data_q[7];  // MSB first on the wire
  assign data = data_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      data_q <= '0;
    end else if (load) begin
      data_q <= load_data;
    end else if (bit_shift) begin
      data_q <= {data_q[6:0], serial_in};  // TX and RX share one register
    end
  end

  // FSM loads on slot end and shifts on drive or sample quarters
  a_load_xor_shift : assert property (
    @(posedge clk) disable iff (reset)
    !(load && bit_shift)
  ) else $error("Shift register loaded and shifted in the same cycle");

endmodule

// File: list.f
hdl/i2c_pkg.sv
hdl/i2c_bit_timer.sv
hdl/i2c_shift_reg.sv
hdl/i2c_master_fsm.sv
hdl/i2c_master_top.sv
sim/i2c_slave_model.sv
sim/tb_i2c_master.sv

// File: sim/i2c_slave_model.sv
module i2c_slave_model (
  input  logic clk,
  input  logic reset,
  input  logic scl,      // Wired SCL level
  input  logic sda,      // Wired SDA level
  output logic sda_low   // Open-drain pull-down on SDA
);

  localparam logic [6:0] OWN_ADDR = 7'h2A;

  typedef enum logic [2:0] {
    SL_IDLE, SL_ADDR, SL_ADDR_ACK, SL_WRITE, SL_WRITE_ACK, SL_READ, SL_WAIT_STOP
  } slave_state_e;

  slave_state_e state_q;
  logic         scl_q;    // Bus levels one cycle back
  logic         sda_q;
  logic [3:0]   cnt_q;    // SCL rises in the current byte
  logic [7:0]   shift_q;  // Incoming byte
  logic [7:0]   reg_q;    // Data register
  logic         rd_q;     // R/W bit of the address byte

  // Runs on the falling clk edge, half a cycle away from the master
  always @(negedge clk or posedge reset) begin
    if (reset) begin
      state_q <= SL_IDLE;
      scl_q   <= 1'b1;
      sda_q   <= 1'b1;
      cnt_q   <= '0;
      shift_q <= '0;
      reg_q   <= 8'h5C;
      rd_q    <= 1'b0;
      sda_low <= 1'b0;
    end else begin
      scl_q <= scl;
      sda_q <= sda;
      if (scl && scl_q && sda_q && !sda) begin  // START
        state_q <= SL_ADDR;
        cnt_q   <= '0;
        sda_low <= 1'b0;
      end else if (scl && scl_q && !sda_q && sda) begin  // STOP
        state_q <= SL_IDLE;
        sda_low <= 1'b0;
      end else if (scl && !scl_q) begin  // SCL rise, sample
        if ((state_q == SL_ADDR) || (state_q == SL_WRITE)) shift_q <= {shift_q[6:0], sda};
        if ((state_q == SL_ADDR) || (state_q == SL_WRITE) || (state_q == SL_READ))
          cnt_q <= cnt_q + 4'd1;
      end else if (!scl && scl_q) begin  // SCL fall, drive
        case (state_q)
          SL_ADDR: begin
            if (cnt_q == 4'd8) begin
              rd_q <= shift_q[0];
              if (shift_q[7:1] == OWN_ADDR) begin
                sda_low <= 1'b1;  // ACK own address only
                state_q <= SL_ADDR_ACK;
              end else begin
                state_q <= SL_WAIT_STOP;
              end
            end
          end
          SL_ADDR_ACK: begin
            cnt_q   <= '0;
            sda_low <= rd_q ? !reg_q[7] : 1'b0;  // First read bit, MSB
            state_q <= rd_q ? SL_READ : SL_WRITE;
          end
          SL_WRITE: begin
            if (cnt_q == 4'd8) begin
              if (shift_q != 8'hFF) begin
                reg_q   <= shift_q;
                sda_low <= 1'b1;
                state_q <= SL_WRITE_ACK;
              end else begin
                state_q <= SL_WAIT_STOP;  // NACK, register kept
              end
            end
          end
          SL_WRITE_ACK: begin
            sda_low <= 1'b0;
            state_q <= SL_WAIT_STOP;
          end
          SL_READ: begin
            if (cnt_q == 4'd8) begin
              sda_low <= 1'b0;  // Master answers in the ACK slot
              state_q <= SL_WAIT_STOP;
            end else begin
              sda_low <= !reg_q[3'd7 - cnt_q[2:0]];
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: sim/tb_i2c_master.sv
module tb_i2c_master
  import i2c_pkg::*;
();

  localparam int N_ENTRIES = 10;
  localparam int TXN_CLKS  = BIT_SLOTS_MAX * 4 * QUARTER_CLKS;  // Full transaction
  localparam int NACK_CLKS = 11 * 4 * QUARTER_CLKS;             // Address NACK
  localparam int GAP_CLKS  = 8;                                  // Idle bus check after done

  logic     clk;
  logic     reset;
  logic     start;
  i2c_cmd_t cmd;
  logic     busy;
  logic     done;
  i2c_rsp_t rsp;
  logic     scl_low;
  logic     sda_low;
  logic     slv_sda_low;
  logic     scl;
  logic     sda;
  i2c_cmd_t tab_cmd [N_ENTRIES];
  i2c_rsp_t tab_rsp [N_ENTRIES];
  int       err_cnt   = 0;
  int       done_cnt  = 0;
  int       start_cnt = 0;   // SDA falls with SCL high
  int       stop_cnt  = 0;   // SDA rises with SCL high
  logic     scl_q     = 1'b1;
  logic     sda_q     = 1'b1;

  assign scl = !scl_low;                  // Master is the only SCL driver
  assign sda = !(sda_low || slv_sda_low); // Wired-AND with pull-up

  i2c_master_top i_dut (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .cmd     (cmd),
    .busy    (busy),
    .done    (done),
    .rsp     (rsp),
    .sda_in  (sda),
    .scl_low (scl_low),
    .sda_low (sda_low)
  );

  i2c_slave_model i_slave (
    .clk     (clk),
    .reset   (reset),
    .scl     (scl),
    .sda     (sda),
    .sda_low (slv_sda_low)
  );

  always #20 clk = ~clk;

  // Bus monitor samples mid-cycle when all edges have settled
  always @(negedge clk) begin
    scl_q <= scl;
    sda_q <= sda;
    if (!reset) begin
      if (done) done_cnt++;
      if ((sda != sda_q) && scl && scl_q) begin
        if (!sda) start_cnt++;
        else stop_cnt++;
      end
      if ((sda != sda_q) && (scl != scl_q)) begin
        $display("SDA and SCL changed in the same cycle at time %0t", $time);
        err_cnt++;
      end
    end
  end

  task automatic load_table();
    tab_cmd[0] = {7'h2A, 1'b1, 8'h00};
    tab_rsp[0] = {8'h5C, 1'b0, 1'b0};  // Reset value
    tab_cmd[1] = {7'h2A, 1'b0, 8'hA7};
    tab_rsp[1] = {8'h00, 1'b0, 1'b0};
    tab_cmd[2] = {7'h2A, 1'b1, 8'h00};
    tab_rsp[2] = {8'hA7, 1'b0, 1'b0};  // Round trip
    tab_cmd[3] = {7'h3B, 1'b0, 8'h12};
    tab_rsp[3] = {8'h00, 1'b1, 1'b0};  // Wrong address
    tab_cmd[4] = {7'h15, 1'b1, 8'h00};
    tab_rsp[4] = {8'h00, 1'b1, 1'b0};
    tab_cmd[5] = {7'h2A, 1'b1, 8'h00};
    tab_rsp[5] = {8'hA7, 1'b0, 1'b0};
    tab_cmd[6] = {7'h2A, 1'b0, 8'hFF};
    tab_rsp[6] = {8'h00, 1'b0, 1'b1};  // Data NACK
    tab_cmd[7] = {7'h2A, 1'b1, 8'h00};
    tab_rsp[7] = {8'hA7, 1'b0, 1'b0};  // Unchanged
    tab_cmd[8] = {7'h2A, 1'b0, 8'h3C};
    tab_rsp[8] = {8'h00, 1'b0, 1'b0};
    tab_cmd[9] = {7'h2A, 1'b1, 8'h00};
    tab_rsp[9] = {8'h3C, 1'b0, 1'b0};
  endtask

  task automatic run_entry(input int idx);
    i2c_cmd_t stray;
    int       stray_at;
    int       cycles;
    int       exp_cycles;
    int       done0;
    int       start0;
    int       stop0;
    stray_at   = 2 + int'($urandom % 150);     // Always inside the busy window
    stray      = {7'h2A, 1'b0, 8'($urandom)}; // Would overwrite the register if taken
    exp_cycles = tab_rsp[idx].addr_nack ? NACK_CLKS : TXN_CLKS;
    done0      = done_cnt;
    start0     = start_cnt;
    stop0      = stop_cnt;
    cycles     = 0;
    @(posedge clk);
    start <= 1'b1;
    cmd   <= tab_cmd[idx];
    do begin
      @(posedge clk);
      start <= (cycles == stray_at);
      if (cycles == stray_at) cmd <= stray;
      @(negedge clk);
      cycles++;
      if ((cycles == 1) && (busy !== 1'b1)) begin
        $display("Error: entry %0d busy expected 1 got %h", idx, busy);
        err_cnt++;
      end
      if ((cycles == 1) && (idx > 0) && (rsp !== tab_rsp[idx - 1])) begin
        $display("Error: entry %0d rsp held expected %h got %h", idx, tab_rsp[idx - 1], rsp);
        err_cnt++;
      end
    end while (done !== 1'b1);
    if (rsp !== tab_rsp[idx]) begin
      $display("Error: entry %0d rsp expected %h got %h", idx, tab_rsp[idx], rsp);
      err_cnt++;
    end
    if (cycles != exp_cycles) begin
      $display("Error: entry %0d latency expected %h got %h", idx, exp_cycles, cycles);
      err_cnt++;
    end
    repeat (GAP_CLKS) begin
      @(negedge clk);
      if ((busy !== 1'b0) || (scl !== 1'b1) || (sda !== 1'b1)) begin
        $display("Error: entry %0d busy/scl/sda expected 0/1/1 got %h/%h/%h",
                 idx, busy, scl, sda);
        err_cnt++;
      end
    end
    if (done_cnt != done0 + 1) begin
      $display("Error: entry %0d done count expected %h got %h", idx, 1, done_cnt - done0);
      err_cnt++;
    end
    if ((start_cnt != start0 + 1) || (stop_cnt != stop0 + 1)) begin
      $display("Error: entry %0d start/stop count expected 1/1 got %h/%h",
               idx, start_cnt - start0, stop_cnt - stop0);
      err_cnt++;
    end
  endtask

  initial begin
    void'($urandom(32'h92b0_6ccf));
    clk   = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    cmd   = '0;
    load_table();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (busy !== 1'b0) begin
      $display("Error: busy after reset expected 0 got %h", busy);
      err_cnt++;
    end
    for (int i = 0; i < N_ENTRIES; i++) begin
      run_entry(i);
    end
    $display("Run finished with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog allows one full transaction plus margin per entry
  initial begin
    repeat (N_ENTRIES * (TXN_CLKS + 20)) @(posedge clk);
    $display("Watchdog expired, the run timed out before all entries finished");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
